//--- common/mempool_pkg.sv
// MemPool cluster package
// Cluster sizes, TCDM address fields and the word types shared by
// the tiles, the banks and the NUMA interconnect

`default_nettype none

package mempool_pkg;

  // Cluster topology
  localparam int unsigned NumTiles        = 4;
  localparam int unsigned NumCoresPerTile = 2;
  localparam int unsigned NumCores        = NumTiles * NumCoresPerTile;
  localparam int unsigned NumBanksPerTile = 2;
  localparam int unsigned NumBanks        = NumTiles * NumBanksPerTile;

  // Core bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // TCDM geometry, 64 words per bank
  localparam int unsigned TCDMAddrMemWidth = 6;
  localparam int unsigned ByteOffset       = 2;

  // Return index of a response, one value per core
  localparam int unsigned CoreIdxWidth = $clog2(NumCores);

  // Address map of a core address
  //   [1:0]   byte offset
  //   [4:2]   global bank, word interleaved
  //           bank b lives in tile b/2 as local bank b%2
  //   [10:5]  row inside the bank
  //   above   ignored by the cluster

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [CoreIdxWidth-1:0] core_addr_t;

  // Address inside a tile
  // Local bank bit sits on top of the row
  typedef logic [TCDMAddrMemWidth+$clog2(NumBanksPerTile)-1:0] tile_addr_t;

endpackage : mempool_pkg

`default_nettype wire

//--- numa_interconnect/rr_arbiter.sv
// Round-robin arbiter
// Picks one requesting core for a single TCDM bank, searching from a
// rotating priority pointer that moves past each winner

`timescale 1ns/100ps
`default_nettype none

module rr_arbiter
  import mempool_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  wire logic [NumCores-1:0] req_i,
  output logic      [NumCores-1:0] gnt_o
);

  core_addr_t ptr_q;
  core_addr_t winner;
  logic       found;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    gnt_o  = '0;
    winner = ptr_q;
    found  = 1'b0;
    for (int unsigned i = 0; i < NumCores; i++) begin
      cand = (ptr_q + i) % NumCores;
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        winner      = core_addr_t'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  // Lowest priority goes to the core that just won
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= core_addr_t'((winner + 1) % NumCores);
    end
  end

  a_gnt_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
    else $error("arbiter grant is not one-hot or goes to an idle core");

endmodule : rr_arbiter

`default_nettype wire

//--- numa_interconnect/numa_interconnect.sv
// NUMA interconnect
// Full request crossbar from every core to every TCDM bank with one
// round-robin arbiter per bank, and a response crossbar that returns
// read data to the core named by the response index

`timescale 1ns/100ps
`default_nettype none

module numa_interconnect
  import mempool_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  // Core side
  input  wire logic       [NumCores-1:0] req_i,
  input  wire addr_t      [NumCores-1:0] add_i,
  input  wire logic       [NumCores-1:0] wen_i,
  input  wire data_t      [NumCores-1:0] wdata_i,
  input  wire be_t        [NumCores-1:0] be_i,
  output logic            [NumCores-1:0] gnt_o,
  output logic            [NumCores-1:0] vld_o,
  output data_t           [NumCores-1:0] rdata_o,
  // Bank side
  output logic            [NumBanks-1:0] req_o,
  output tile_addr_t      [NumBanks-1:0] add_o,
  output logic            [NumBanks-1:0] wen_o,
  output data_t           [NumBanks-1:0] wdata_o,
  output be_t             [NumBanks-1:0] be_o,
  output core_addr_t      [NumBanks-1:0] idx_o,
  input  wire logic       [NumBanks-1:0] gnt_i,
  input  wire logic       [NumBanks-1:0] vld_i,
  input  wire core_addr_t [NumBanks-1:0] idx_i,
  input  wire data_t      [NumBanks-1:0] rdata_i
);

  logic       [NumCores-1:0][$clog2(NumBanks)-1:0] bank_sel;
  tile_addr_t [NumCores-1:0]                       core_taddr;
  logic       [NumBanks-1:0][NumCores-1:0]         bank_req;
  logic       [NumBanks-1:0][NumCores-1:0]         arb_gnt;
  logic       [NumCores-1:0][NumBanks-1:0]         resp_match;

  // Global bank and in-tile address of each core request
  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      bank_sel[c]   = add_i[c][ByteOffset +: $clog2(NumBanks)];
      core_taddr[c] = {add_i[c][ByteOffset +: $clog2(NumBanksPerTile)],
                       add_i[c][ByteOffset + $clog2(NumBanks) +: TCDMAddrMemWidth]};
    end
  end

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int c = 0; c < NumCores; c++) begin
        bank_req[b][c] = req_i[c] && (int'(bank_sel[c]) == b);
      end
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    core_addr_t winner;

    rr_arbiter u_arb (
      .clk_i   (clk_i      ),
      .arst_n_i(arst_n_i   ),
      .req_i   (bank_req[b]),
      .gnt_o   (arb_gnt[b] )
    );

    always_comb begin
      winner = '0;
      for (int c = 0; c < NumCores; c++) begin
        if (arb_gnt[b][c]) begin
          winner = core_addr_t'(c);
        end
      end
    end

    // Winner's fields go to the bank, tagged with its core index
    assign req_o[b]   = |arb_gnt[b];
    assign add_o[b]   = core_taddr[winner];
    assign wen_o[b]   = wen_i[winner];
    assign wdata_o[b] = wdata_i[winner];
    assign be_o[b]    = be_i[winner];
    assign idx_o[b]   = winner;
  end : gen_bank

  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      gnt_o[c] = 1'b0;
      for (int b = 0; b < NumBanks; b++) begin
        gnt_o[c] |= arb_gnt[b][c] && gnt_i[b];
      end
    end
  end

  // Equal read latency keeps responses to one core apart, no arbitration here
  always_comb begin
    for (int c = 0; c < NumCores; c++) begin
      vld_o[c]   = 1'b0;
      rdata_o[c] = '0;
      for (int b = 0; b < NumBanks; b++) begin
        resp_match[c][b] = vld_i[b] && (int'(idx_i[b]) == c);
        if (resp_match[c][b]) begin
          vld_o[c]   = 1'b1;
          rdata_o[c] = rdata_i[b];
        end
      end
    end
  end

  for (genvar c = 0; c < NumCores; c++) begin : gen_resp_chk
    a_one_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(resp_match[c]))
      else $error("core %0d receives more than one response in a cycle", c);
  end : gen_resp_chk

endmodule : numa_interconnect

`default_nettype wire

//--- mempool_tile/tcdm_bank.sv
// TCDM bank
// Single-port word memory with byte enables; a read returns its data
// one cycle later together with the index of the requesting core

`timescale 1ns/100ps
`default_nettype none

module tcdm_bank
  import mempool_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,
  input  wire logic                        req_i,
  input  wire logic                        wen_i,
  input  wire logic [TCDMAddrMemWidth-1:0] addr_i,
  input  wire data_t                       wdata_i,
  input  wire be_t                         be_i,
  input  wire core_addr_t                  ret_addr_i,
  output logic                             vld_o,
  output core_addr_t                       resp_addr_o,
  output data_t                            rdata_o
);

  data_t mem [2**TCDMAddrMemWidth];

  // Storage and read data path
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (wen_i) begin
        for (int i = 0; i < BeWidth; i++) begin
          if (be_i[i]) begin
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o     <= mem[addr_i];
        resp_addr_o <= ret_addr_i;
      end
    end
  end

  // Only reads produce a response
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= req_i && !wen_i;
    end
  end

endmodule : tcdm_bank

`default_nettype wire

//--- mempool_tile/mempool_tile.sv
// MemPool tile
// Holds the local TCDM banks of one tile, grants every incoming bank
// request and adds a response register for the second read cycle

`timescale 1ns/100ps
`default_nettype none

module mempool_tile
  import mempool_pkg::*;
(
  input  wire logic                             clk_i,
  input  wire logic                             arst_n_i,
  input  wire logic       [$clog2(NumTiles)-1:0] tile_id_i,
  // TCDM bank ports
  input  wire logic       [NumBanksPerTile-1:0] mem_req_i,
  input  wire core_addr_t [NumBanksPerTile-1:0] mem_ret_addr_i,
  input  wire tile_addr_t [NumBanksPerTile-1:0] mem_addr_i,
  input  wire logic       [NumBanksPerTile-1:0] mem_wen_i,
  input  wire data_t      [NumBanksPerTile-1:0] mem_wdata_i,
  input  wire be_t        [NumBanksPerTile-1:0] mem_be_i,
  output logic            [NumBanksPerTile-1:0] mem_gnt_o,
  output logic            [NumBanksPerTile-1:0] mem_vld_o,
  output core_addr_t      [NumBanksPerTile-1:0] mem_resp_addr_o,
  output data_t           [NumBanksPerTile-1:0] mem_rdata_o
);

  logic       [NumBanksPerTile-1:0][$clog2(NumBanksPerTile)-1:0] port_bank;
  logic       [NumBanksPerTile-1:0]                              bank_req;
  logic       [NumBanksPerTile-1:0]                              bank_wen;
  logic       [NumBanksPerTile-1:0][TCDMAddrMemWidth-1:0]        bank_row;
  data_t      [NumBanksPerTile-1:0]                              bank_wdata;
  be_t        [NumBanksPerTile-1:0]                              bank_be;
  core_addr_t [NumBanksPerTile-1:0]                              bank_ret;
  logic       [NumBanksPerTile-1:0]                              bank_vld;
  core_addr_t [NumBanksPerTile-1:0]                              bank_resp;
  data_t      [NumBanksPerTile-1:0]                              bank_rdata;
  logic       [NumBanksPerTile-1:0]                              vld_q;
  core_addr_t [NumBanksPerTile-1:0]                              resp_q;
  data_t      [NumBanksPerTile-1:0]                              rdata_q;

  // Banks never stall
  assign mem_gnt_o = mem_req_i;

  // Steer each port to the bank named by its local bank bit
  always_comb begin
    for (int p = 0; p < NumBanksPerTile; p++) begin
      port_bank[p] = mem_addr_i[p][TCDMAddrMemWidth +: $clog2(NumBanksPerTile)];
    end
    for (int k = 0; k < NumBanksPerTile; k++) begin
      bank_req[k]   = 1'b0;
      bank_wen[k]   = 1'b0;
      bank_row[k]   = '0;
      bank_wdata[k] = '0;
      bank_be[k]    = '0;
      bank_ret[k]   = '0;
      for (int p = 0; p < NumBanksPerTile; p++) begin
        if (mem_req_i[p] && (int'(port_bank[p]) == k)) begin
          bank_req[k]   = 1'b1;
          bank_wen[k]   = mem_wen_i[p];
          bank_row[k]   = mem_addr_i[p][TCDMAddrMemWidth-1:0];
          bank_wdata[k] = mem_wdata_i[p];
          bank_be[k]    = mem_be_i[p];
          bank_ret[k]   = mem_ret_addr_i[p];
        end
      end
    end
  end

  for (genvar k = 0; k < NumBanksPerTile; k++) begin : gen_bank
    tcdm_bank u_bank (
      .clk_i      (clk_i        ),
      .arst_n_i   (arst_n_i     ),
      .req_i      (bank_req[k]  ),
      .wen_i      (bank_wen[k]  ),
      .addr_i     (bank_row[k]  ),
      .wdata_i    (bank_wdata[k]),
      .be_i       (bank_be[k]   ),
      .ret_addr_i (bank_ret[k]  ),
      .vld_o      (bank_vld[k]  ),
      .resp_addr_o(bank_resp[k] ),
      .rdata_o    (bank_rdata[k])
    );
  end : gen_bank

  // Response register, second cycle of read latency
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= bank_vld;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_q  <= bank_resp;
    rdata_q <= bank_rdata;
  end

  assign mem_vld_o       = vld_q;
  assign mem_resp_addr_o = resp_q;
  assign mem_rdata_o     = rdata_q;

  for (genvar p = 0; p < NumBanksPerTile; p++) begin : gen_chk
    a_bank_bit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_req_i[p] |-> (int'(port_bank[p]) == p))
      else $error("tile %0d: port %0d carries a request for another bank", tile_id_i, p);

    a_resp_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_vld_o[p] |-> (int'(mem_resp_addr_o[p]) < NumCores))
      else $error("tile %0d: bank %0d response index out of range", tile_id_i, p);
  end : gen_chk

endmodule : mempool_tile

`default_nettype wire

//--- hdl/mempool.sv
// MemPool cluster top level
// Four tiles of TCDM banks behind a full NUMA crossbar; the memory
// ports of the eight cores are brought out at the top

`timescale 1ns/100ps
`default_nettype none

module mempool
  import mempool_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  // Core data ports
  input  wire logic  [NumCores-1:0] tcdm_req_i,
  input  wire addr_t [NumCores-1:0] tcdm_addr_i,
  input  wire logic  [NumCores-1:0] tcdm_wen_i,
  input  wire data_t [NumCores-1:0] tcdm_wdata_i,
  input  wire be_t   [NumCores-1:0] tcdm_be_i,
  output logic       [NumCores-1:0] tcdm_gnt_o,
  output logic       [NumCores-1:0] tcdm_vld_o,
  output data_t      [NumCores-1:0] tcdm_rdata_o
);

  // Bank side of the crossbar
  logic       [NumBanks-1:0] bank_req;
  tile_addr_t [NumBanks-1:0] bank_addr;
  logic       [NumBanks-1:0] bank_wen;
  data_t      [NumBanks-1:0] bank_wdata;
  be_t        [NumBanks-1:0] bank_be;
  core_addr_t [NumBanks-1:0] bank_ret_addr;
  logic       [NumBanks-1:0] bank_gnt;
  logic       [NumBanks-1:0] bank_vld;
  core_addr_t [NumBanks-1:0] bank_resp_addr;
  data_t      [NumBanks-1:0] bank_rdata;

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tiles
    mempool_tile u_tile (
      .clk_i          (clk_i                                                  ),
      .arst_n_i       (arst_n_i                                               ),
      .tile_id_i      (($clog2(NumTiles))'(t)                                 ),
      .mem_req_i      (bank_req[NumBanksPerTile*t +: NumBanksPerTile]         ),
      .mem_ret_addr_i (bank_ret_addr[NumBanksPerTile*t +: NumBanksPerTile]    ),
      .mem_addr_i     (bank_addr[NumBanksPerTile*t +: NumBanksPerTile]        ),
      .mem_wen_i      (bank_wen[NumBanksPerTile*t +: NumBanksPerTile]         ),
      .mem_wdata_i    (bank_wdata[NumBanksPerTile*t +: NumBanksPerTile]       ),
      .mem_be_i       (bank_be[NumBanksPerTile*t +: NumBanksPerTile]          ),
      .mem_gnt_o      (bank_gnt[NumBanksPerTile*t +: NumBanksPerTile]         ),
      .mem_vld_o      (bank_vld[NumBanksPerTile*t +: NumBanksPerTile]         ),
      .mem_resp_addr_o(bank_resp_addr[NumBanksPerTile*t +: NumBanksPerTile]   ),
      .mem_rdata_o    (bank_rdata[NumBanksPerTile*t +: NumBanksPerTile]       )
    );
  end : gen_tiles

  numa_interconnect u_interco (
    .clk_i   (clk_i         ),
    .arst_n_i(arst_n_i      ),
    .req_i   (tcdm_req_i    ),
    .add_i   (tcdm_addr_i   ),
    .wen_i   (tcdm_wen_i    ),
    .wdata_i (tcdm_wdata_i  ),
    .be_i    (tcdm_be_i     ),
    .gnt_o   (tcdm_gnt_o    ),
    .vld_o   (tcdm_vld_o    ),
    .rdata_o (tcdm_rdata_o  ),
    .req_o   (bank_req      ),
    .add_o   (bank_addr     ),
    .wen_o   (bank_wen      ),
    .wdata_o (bank_wdata    ),
    .be_o    (bank_be       ),
    .idx_o   (bank_ret_addr ),
    .gnt_i   (bank_gnt      ),
    .vld_i   (bank_vld      ),
    .idx_i   (bank_resp_addr),
    .rdata_i (bank_rdata    )
  );

endmodule : mempool

`default_nettype wire

//--- bench/tb_mempool.sv
// MemPool cluster testbench
// Plays the eight cores against the cluster, keeps a reference memory
// and checks grants, read data and read response timing

`timescale 1ns/100ps
`default_nettype none

module tb_mempool
  import mempool_pkg::*;
();

  localparam int unsigned MaxCycles  = 4000;
  localparam int unsigned ModelWords = 512;

  typedef struct packed {
    logic  wen;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } op_t;

  logic                 clk;
  logic                 arst_n;
  logic  [NumCores-1:0] req;
  addr_t [NumCores-1:0] addr;
  logic  [NumCores-1:0] wen;
  data_t [NumCores-1:0] wdata;
  be_t   [NumCores-1:0] be;
  logic  [NumCores-1:0] gnt;
  logic  [NumCores-1:0] vld;
  data_t [NumCores-1:0] rdata;

  // Reference memory, indexed by address bits 10:2
  data_t       model_mem [ModelWords];
  op_t         op_q      [NumCores][$];
  data_t       exp_data  [NumCores][$];
  int          exp_cyc   [NumCores][$];
  int unsigned wait_cnt  [NumCores];
  int          cycles;
  int          errors;
  int          checks;
  logic        no_wait;
  integer      seed;
  string       test_name;

  mempool u_mempool (
    .clk_i       (clk   ),
    .arst_n_i    (arst_n),
    .tcdm_req_i  (req   ),
    .tcdm_addr_i (addr  ),
    .tcdm_wen_i  (wen   ),
    .tcdm_wdata_i(wdata ),
    .tcdm_be_i   (be    ),
    .tcdm_gnt_o  (gnt   ),
    .tcdm_vld_o  (vld   ),
    .tcdm_rdata_o(rdata )
  );

  always #5 clk = ~clk;

  function automatic addr_t addr_of(int unsigned bank, int unsigned row);
    return addr_t'((row << 5) | (bank << 2));
  endfunction

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t en);
    data_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (en[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  task automatic push_op(input int unsigned c, input logic w, input addr_t a,
                         input data_t d, input be_t e);
    op_t op;
    op.wen   = w;
    op.addr  = a;
    op.wdata = d;
    op.be    = e;
    op_q[c].push_back(op);
  endtask

  // Watchdog and cycle count
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Done: %0d checks, %0d errors", checks, errors + 1);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Each core drives the head of its queue until it is granted
  always @(posedge clk) begin
    op_t op;
    #1;
    for (int c = 0; c < NumCores; c++) begin
      if (op_q[c].size() > 0) begin
        op       = op_q[c][0];
        req[c]   = 1'b1;
        wen[c]   = op.wen;
        addr[c]  = op.addr;
        wdata[c] = op.wdata;
        be[c]    = op.be;
      end else begin
        req[c]   = 1'b0;
        wen[c]   = 1'b0;
        addr[c]  = '0;
        wdata[c] = '0;
        be[c]    = '0;
      end
    end
  end

  // Sampled mid-cycle, where grants and responses are stable
  always @(negedge clk) begin
    int req_cnt [NumBanks];
    int gnt_cnt [NumBanks];
    int b;
    int w;
    if (arst_n) begin
      for (int c = 0; c < NumCores; c++) begin
        if (vld[c] && exp_data[c].size() == 0) begin
          $display("Core %0d got a read response with no read pending in %s", c, test_name);
          errors++;
        end else if (vld[c]) begin
          checks++;
          if (rdata[c] !== exp_data[c][0]) begin
            $display("MISMATCH %s: core %0d rdata expected %h actual %h",
                     test_name, c, exp_data[c][0], rdata[c]);
            errors++;
          end
          if (cycles != exp_cyc[c][0]) begin
            $display("MISMATCH %s: core %0d response cycle expected %0d actual %0d",
                     test_name, c, exp_cyc[c][0], cycles);
            errors++;
          end
          void'(exp_data[c].pop_front());
          void'(exp_cyc[c].pop_front());
        end
      end
      for (int k = 0; k < NumBanks; k++) begin
        req_cnt[k] = 0;
        gnt_cnt[k] = 0;
      end
      for (int c = 0; c < NumCores; c++) begin
        if (gnt[c] && !req[c]) begin
          $display("Core %0d was granted without a request in %s", c, test_name);
          errors++;
        end
        if (req[c]) begin
          b = int'(addr[c][4:2]);
          w = int'(addr[c][10:2]);
          req_cnt[b]++;
          if (gnt[c]) begin
            gnt_cnt[b]++;
            wait_cnt[c] = 0;
            if (wen[c]) begin
              model_mem[w] = merge_bytes(model_mem[w], wdata[c], be[c]);
            end else begin
              exp_data[c].push_back(model_mem[w]);
              exp_cyc[c].push_back(cycles + 2);
            end
            if (op_q[c].size() > 0) void'(op_q[c].pop_front());
          end else begin
            wait_cnt[c]++;
            if (no_wait || wait_cnt[c] >= NumCores) begin
              $display("Core %0d waited %0d cycles for a grant in %s",
                       c, wait_cnt[c], test_name);
              errors++;
            end
          end
        end
      end
      for (int k = 0; k < NumBanks; k++) begin
        if (req_cnt[k] > 0 && gnt_cnt[k] != 1) begin
          $display("MISMATCH %s: grants to bank %0d expected 1 actual %0d",
                   test_name, k, gnt_cnt[k]);
          errors++;
        end
      end
    end
  end

  // Waits for the request queues to drain and for the last reads to return
  task automatic wait_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int c = 0; c < NumCores; c++) begin
        if (op_q[c].size() != 0) busy = 1'b1;
      end
    end
    repeat (3) @(posedge clk);
    for (int c = 0; c < NumCores; c++) begin
      if (exp_data[c].size() != 0) begin
        $display("Core %0d still has %0d reads pending in %s",
                 c, exp_data[c].size(), test_name);
        errors++;
        exp_data[c].delete();
        exp_cyc[c].delete();
      end
    end
  endtask

  task automatic check_reset();
    test_name = "reset_state";
    repeat (5) begin
      @(negedge clk);
      checks++;
      if (vld !== '0) begin
        $display("MISMATCH %s: vld expected %h actual %h", test_name, 8'h00, vld);
        errors++;
      end
    end
    @(posedge clk);
    #1 arst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      checks++;
      if (vld !== '0) begin
        $display("MISMATCH %s: vld expected %h actual %h", test_name, 8'h00, vld);
        errors++;
      end
    end
  endtask

  // Core c fills bank c, value built from the whole word address
  task automatic fill_memory();
    logic [8:0] word;
    test_name = "fill_memory";
    for (int r = 0; r < 64; r++) begin
      for (int c = 0; c < NumCores; c++) begin
        word = 9'(r * 8 + c);
        push_op(c, 1'b1, addr_of(c, r), {7'h2d, word, 7'h13, ~word}, 4'hf);
      end
    end
    wait_idle();
  endtask

  task automatic single_rw();
    int rows [4];
    test_name = "single_rw";
    rows = '{0, 13, 37, 63};
    for (int b = 0; b < NumBanks; b++) begin
      for (int i = 0; i < 4; i++) begin
        push_op(0, 1'b1, addr_of(b, rows[i]), 32'hc0de_0000 + b * 256 + rows[i], 4'hf);
      end
    end
    for (int b = 0; b < NumBanks; b++) begin
      for (int i = 0; i < 4; i++) begin
        push_op(0, 1'b0, addr_of(b, rows[i]), '0, 4'hf);
      end
    end
    wait_idle();
  endtask

  task automatic byte_enables();
    test_name = "byte_enables";
    push_op(2, 1'b1, addr_of(5, 9), 32'h1234_5678, 4'hf);
    for (int e = 0; e < 16; e++) begin
      push_op(2, 1'b1, addr_of(5, 9), data_t'($random(seed)), be_t'(e));
      push_op(2, 1'b0, addr_of(5, 9), '0, 4'hf);
    end
    wait_idle();
  endtask

  task automatic bank_conflict();
    test_name = "bank_conflict";
    for (int c = 0; c < NumCores; c++) begin
      push_op(c, 1'b0, addr_of(3, 40 + c), '0, 4'hf);
    end
    wait_idle();
  endtask

  task automatic parallel_reads();
    test_name = "parallel_reads";
    no_wait   = 1'b1;
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < NumCores; c++) begin
        push_op(c, 1'b0, addr_of(c, r * 7), '0, 4'hf);
      end
    end
    wait_idle();
    no_wait = 1'b0;
  endtask

  task automatic random_traffic();
    int unsigned c;
    logic [31:0] rnd;
    test_name = "random_traffic";
    for (int i = 0; i < 300; i++) begin
      c   = $unsigned($random(seed)) % NumCores;
      rnd = $random(seed);
      push_op(c, rnd[0], addr_t'($random(seed)), data_t'($random(seed)),
              be_t'($random(seed)));
    end
    wait_idle();
  endtask

  initial begin
    seed      = 32'hef6e_7369;
    clk       = 1'b0;
    arst_n    = 1'b0;
    req       = '0;
    addr      = '0;
    wen       = '0;
    wdata     = '0;
    be        = '0;
    cycles    = 0;
    errors    = 0;
    checks    = 0;
    no_wait   = 1'b0;
    for (int c = 0; c < NumCores; c++) wait_cnt[c] = 0;
    check_reset();
    fill_memory();
    single_rw();
    byte_enables();
    bank_conflict();
    parallel_reads();
    random_traffic();
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_mempool

`default_nettype wire

//--- vlog.f
common/mempool_pkg.sv
numa_interconnect/rr_arbiter.sv
numa_interconnect/numa_interconnect.sv
mempool_tile/tcdm_bank.sv
mempool_tile/mempool_tile.sv
hdl/mempool.sv
bench/tb_mempool.sv

//--- run.sh
#!/bin/sh
# Build and run the MemPool cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_mempool -Mdir obj_dir -o tb_mempool
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_mempool)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
